// ==== verilog/vcache_params.svh ====
// global sizes for the vector cache slice
// the load path assumes 32-bit words with byte lanes
// VC_SETS must be a power of two, one word per set
// address and data widths are shared by the DMA side
`ifndef VCACHE_PARAMS_SVH
`define VCACHE_PARAMS_SVH

// byte address width
`define VC_ADDR_W 16

// word width
`define VC_DATA_W 32

// direct-mapped sets
`define VC_SETS 4

// profiler counter width
`define VC_CTR_W 32

`endif

// ==== verilog/vcache_pkg.sv ====
// shared types for the vector cache slice
// word addresses are byte addresses without the two offset bits
// data_size_op encoding is 00 byte, 01 half, 10 word
`include "vcache_params.svh"

package vcache_pkg;

  typedef logic [`VC_ADDR_W-3:0]   vcache_waddr_t;
  typedef logic [`VC_DATA_W-1:0]   vcache_word_t;
  typedef logic [`VC_DATA_W/8-1:0] vcache_mask_t;

  typedef enum logic [2:0] {
    OP_LD,
    OP_SM,
    OP_AMOSWAP,
    OP_AMOOR,
    OP_AFL,
    OP_AINV
  } vcache_op_e;

  // response class seen by the result stage
  typedef enum logic [1:0] {
    CLS_LD,
    CLS_ST,
    CLS_AMO,
    CLS_MAINT   // afl and ainv
  } vcache_class_e;

  typedef struct packed {
    logic          ld_op;
    logic          st_op;
    logic          amoswap_op;
    logic          amoor_op;
    logic          afl_op;
    logic          ainv_op;
    logic [1:0]    data_size_op;
    logic          sigext_op;
    vcache_mask_t  mask;
    vcache_waddr_t word_addr;
    logic [1:0]    byte_off;
    vcache_word_t  data;
  } vcache_decode_s;

  typedef struct packed {
    vcache_word_t  data;
    logic [1:0]    byte_off;
    logic [1:0]    data_size_op;
    logic          sigext_op;
    vcache_class_e op_class;
    logic          was_miss;
  } vcache_resp_s;

  typedef struct packed {
    logic ld;
    logic st;
    logic amo;
    logic miss_ld;
    logic miss_st;
    logic miss_cycle;
    logic idle_cycle;
    logic dma_read;
    logic dma_write;
  } vcache_event_s;

  typedef struct packed {
    logic          write_not_read;
    vcache_waddr_t addr;
    vcache_word_t  data;
  } vcache_dma_pkt_s;

  typedef enum logic [3:0] {
    STAT_LD,
    STAT_ST,
    STAT_AMO,
    STAT_MISS_LD,
    STAT_MISS_ST,
    STAT_MISS_CYC,
    STAT_IDLE_CYC,
    STAT_DMA_RD,
    STAT_DMA_WR
  } vcache_stat_e;

endpackage

// ==== verilog/vcache_stage_if.sv ====
// valid/ready link between two pipeline stages
// a transfer happens on an edge with valid and ready both high
// payload must stay steady while valid is high and ready is low
`timescale 1ns/1ps

interface vcache_stage_if #(
  parameter type payload_t = logic
) ();

  logic     valid;   // from producer
  logic     ready;   // from consumer
  payload_t payload;

  modport producer (
    output valid,
    output payload,
    input  ready
  );

  modport consumer (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// ==== verilog/vcache_decode.sv ====
// request slot in front of the execute stage
// one entry, refilled in the same cycle it drains
// amo requests always act on the full word
// ready stays low for one cycle after reset
`timescale 1ns/1ps
`include "vcache_params.svh"

module vcache_decode
  import vcache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_v_i,
  output logic                    req_ready_o,
  input  vcache_op_e              req_op_i,
  input  logic [`VC_ADDR_W-1:0]   req_addr_i,
  input  logic [`VC_DATA_W-1:0]   req_data_i,
  input  logic [`VC_DATA_W/8-1:0] req_mask_i,
  input  logic [1:0]              req_size_i,
  input  logic                    req_sigext_i,
  vcache_stage_if.producer        out_o
);

  logic           en_r;       // set one cycle after reset
  logic           slot_v_r;
  vcache_decode_s slot_r;
  vcache_decode_s dec;
  logic           accept;
  logic           is_amo;

  assign is_amo      = (req_op_i == OP_AMOSWAP) || (req_op_i == OP_AMOOR);
  assign req_ready_o = en_r & (~slot_v_r | out_o.ready);  // empty or draining
  assign accept      = req_v_i & req_ready_o;

  always_comb begin
    dec.ld_op        = (req_op_i == OP_LD);
    dec.st_op        = (req_op_i == OP_SM);
    dec.amoswap_op   = (req_op_i == OP_AMOSWAP);
    dec.amoor_op     = (req_op_i == OP_AMOOR);
    dec.afl_op       = (req_op_i == OP_AFL);
    dec.ainv_op      = (req_op_i == OP_AINV);
    dec.data_size_op = is_amo ? 2'b10 : req_size_i;  // amo returns the whole word
    dec.sigext_op    = req_sigext_i;
    dec.mask         = is_amo ? '1 : req_mask_i;
    dec.word_addr    = req_addr_i[`VC_ADDR_W-1:2];
    dec.byte_off     = req_addr_i[1:0];
    dec.data         = req_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_r     <= 1'b0;
      slot_v_r <= 1'b0;
    end else begin
      en_r     <= 1'b1;
      slot_v_r <= accept | (slot_v_r & ~out_o.ready);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_r <= dec;
    end
  end

  assign out_o.valid   = slot_v_r;
  assign out_o.payload = slot_r;

endmodule

// ==== verilog/vcache_execute.sv ====
// direct-mapped, write-back, write-allocate cache array with miss handler
// works on the item held by decode, so a hit leaves in the same cycle
// a miss refills the line first, then completes as a hit with was_miss set
// a dirty victim or a dirty afl goes out as one DMA write before anything else
// store data arrives already placed in its byte lanes
// one DMA packet at a time; read data must come back after the yumi
`timescale 1ns/1ps
`include "vcache_params.svh"

module vcache_execute
  import vcache_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  vcache_stage_if.consumer in_i,
  vcache_stage_if.producer out_o,
  output vcache_dma_pkt_s  dma_pkt_o,
  output logic             dma_v_o,
  input  logic             dma_yumi_i,
  input  logic             dma_data_v_i,
  input  vcache_word_t     dma_data_i,
  output vcache_event_s    event_o
);

  localparam int IDX_W = $clog2(`VC_SETS);
  localparam int TAG_W = `VC_ADDR_W - 2 - IDX_W;

  typedef enum logic [1:0] {S_READY, S_WRITEBACK, S_FILL} state_e;

  state_e              state_r;
  logic [TAG_W-1:0]    tag_r [`VC_SETS];
  vcache_word_t        data_r [`VC_SETS];
  logic [`VC_SETS-1:0] valid_r;
  logic [`VC_SETS-1:0] dirty_r;
  logic                fill_sent_r;  // read packet taken, data pending
  logic                was_miss_r;
  vcache_event_s       event_r;
  vcache_event_s       event_next;

  vcache_decode_s      req;
  logic [IDX_W-1:0]    idx;
  logic [TAG_W-1:0]    tag;
  logic                hit;
  logic                need_line;
  logic                miss_now;
  logic                flush_now;
  logic                done;
  logic                fire;
  logic                wr_hit;
  logic                fill_done;
  vcache_word_t        old_word;
  vcache_word_t        new_word;
  vcache_resp_s        resp;

  assign req       = in_i.payload;
  assign idx       = req.word_addr[IDX_W-1:0];
  assign tag       = req.word_addr[`VC_ADDR_W-3:IDX_W];
  assign hit       = valid_r[idx] & (tag_r[idx] == tag);
  assign need_line = req.ld_op | req.st_op | req.amoswap_op | req.amoor_op;
  assign miss_now  = need_line & ~hit;
  assign flush_now = req.afl_op & hit & dirty_r[idx];
  assign done      = in_i.valid & (state_r == S_READY) & ~miss_now & ~flush_now;
  assign fire      = done & out_o.ready;
  assign wr_hit    = fire & (req.st_op | req.amoswap_op | req.amoor_op);
  assign fill_done = (state_r == S_FILL) & fill_sent_r & dma_data_v_i;
  assign old_word  = data_r[idx];

  // store merge and amo update
  always_comb begin
    new_word = old_word;
    if (req.amoswap_op) begin
      new_word = req.data;
    end else if (req.amoor_op) begin
      new_word = old_word | req.data;
    end else begin
      for (int b = 0; b < `VC_DATA_W/8; b++) begin
        if (req.mask[b]) begin
          new_word[8*b +: 8] = req.data[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    resp.data         = old_word;  // old word for loads and amos
    resp.byte_off     = req.byte_off;
    resp.data_size_op = req.data_size_op;
    resp.sigext_op    = req.sigext_op;
    resp.was_miss     = was_miss_r;
    if (req.ld_op) begin
      resp.op_class = CLS_LD;
    end else if (req.st_op) begin
      resp.op_class = CLS_ST;
    end else if (req.amoswap_op | req.amoor_op) begin
      resp.op_class = CLS_AMO;
    end else begin
      resp.op_class = CLS_MAINT;
    end
  end

  assign out_o.valid   = done;
  assign out_o.payload = resp;
  assign in_i.ready    = fire;

  assign dma_v_o = (state_r == S_WRITEBACK) | ((state_r == S_FILL) & ~fill_sent_r);

  always_comb begin
    if (state_r == S_WRITEBACK) begin
      dma_pkt_o.write_not_read = 1'b1;
      dma_pkt_o.addr           = {tag_r[idx], idx};  // victim line
      dma_pkt_o.data           = old_word;
    end else begin
      dma_pkt_o.write_not_read = 1'b0;
      dma_pkt_o.addr           = req.word_addr;
      dma_pkt_o.data           = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= S_READY;
      valid_r     <= '0;
      dirty_r     <= '0;
      fill_sent_r <= 1'b0;
      was_miss_r  <= 1'b0;
    end else begin
      case (state_r)
        S_READY: begin
          if (fire) begin
            was_miss_r <= 1'b0;
            if (wr_hit) begin
              dirty_r[idx] <= 1'b1;
            end
            if (req.ainv_op & hit) begin
              valid_r[idx] <= 1'b0;  // dropped without writeback
              dirty_r[idx] <= 1'b0;
            end
          end else if (in_i.valid & (miss_now | flush_now)) begin
            state_r <= (valid_r[idx] & dirty_r[idx]) ? S_WRITEBACK : S_FILL;
          end
        end
        S_WRITEBACK: begin
          if (dma_yumi_i) begin
            dirty_r[idx] <= 1'b0;
            state_r      <= need_line ? S_FILL : S_READY;  // afl is done here
          end
        end
        S_FILL: begin
          if (dma_v_o & dma_yumi_i) begin
            fill_sent_r <= 1'b1;
          end
          if (fill_done) begin
            valid_r[idx] <= 1'b1;
            dirty_r[idx] <= 1'b0;
            fill_sent_r  <= 1'b0;
            was_miss_r   <= 1'b1;
            state_r      <= S_READY;
          end
        end
        default: state_r <= S_READY;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hit) begin
      data_r[idx] <= new_word;
    end
    if (fill_done) begin
      data_r[idx] <= dma_data_i;
      tag_r[idx]  <= tag;
    end
  end

  always_comb begin
    event_next            = '0;
    event_next.miss_cycle = (state_r != S_READY);
    event_next.idle_cycle = ~in_i.valid & (state_r == S_READY);
    event_next.dma_read   = dma_v_o & dma_yumi_i & ~dma_pkt_o.write_not_read;
    event_next.dma_write  = dma_v_o & dma_yumi_i & dma_pkt_o.write_not_read;
  end

  // registered, one cycle behind the array side
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_r <= '0;
    end else begin
      event_r <= event_next;
    end
  end

  assign event_o = event_r;

endmodule

// ==== verilog/vcache_result.sv ====
// response slot toward the requester, valid/yumi on the outside
// byte and half loads are picked by the byte offset and then extended
// stores, afl and ainv answer with zero data
// retire events pulse in the cycle the response is taken
`timescale 1ns/1ps
`include "vcache_params.svh"

module vcache_result
  import vcache_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  vcache_stage_if.consumer in_i,
  output logic             v_o,
  output vcache_word_t     data_o,
  input  logic             yumi_i,
  output vcache_event_s    event_o
);

  logic         slot_v_r;
  vcache_resp_s slot_r;
  vcache_word_t shifted;
  logic         is_load;
  logic         fire;

  assign in_i.ready = ~slot_v_r | yumi_i;
  assign fire       = slot_v_r & yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_v_r <= 1'b0;
    end else begin
      slot_v_r <= (in_i.valid & in_i.ready) | (slot_v_r & ~yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_i.valid & in_i.ready) begin
      slot_r <= in_i.payload;
    end
  end

  assign v_o     = slot_v_r;
  assign shifted = slot_r.data >> {slot_r.byte_off, 3'b000};
  assign is_load = (slot_r.op_class == CLS_LD) | (slot_r.op_class == CLS_AMO);

  always_comb begin
    data_o = '0;
    if (is_load) begin
      case (slot_r.data_size_op)
        2'b00:   data_o = {{(`VC_DATA_W-8){slot_r.sigext_op & shifted[7]}}, shifted[7:0]};
        2'b01:   data_o = {{(`VC_DATA_W-16){slot_r.sigext_op & shifted[15]}}, shifted[15:0]};
        default: data_o = slot_r.data;  // word, offset ignored
      endcase
    end
  end

  always_comb begin
    event_o         = '0;
    event_o.ld      = fire & (slot_r.op_class == CLS_LD);
    event_o.st      = fire & (slot_r.op_class == CLS_ST);
    event_o.amo     = fire & (slot_r.op_class == CLS_AMO);
    event_o.miss_ld = fire & (slot_r.op_class == CLS_LD) & slot_r.was_miss;
    event_o.miss_st = fire & (slot_r.op_class == CLS_ST) & slot_r.was_miss;
  end

endmodule

// ==== verilog/vcache_profiler.sv ====
// hardware event counters, one per vcache_stat_e entry
// counters saturate at all ones and clear on reset
// stat_o follows stat_sel_i combinationally
// unused select codes read as zero
`timescale 1ns/1ps
`include "vcache_params.svh"

module vcache_profiler
  import vcache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  vcache_event_s        event_i,
  input  vcache_stat_e         stat_sel_i,
  output logic [`VC_CTR_W-1:0] stat_o
);

  localparam int N_STAT = int'(STAT_DMA_WR) + 1;

  logic [`VC_CTR_W-1:0] ctr_r [N_STAT];
  logic [N_STAT-1:0]    inc;

  assign inc[STAT_LD]       = event_i.ld;
  assign inc[STAT_ST]       = event_i.st;
  assign inc[STAT_AMO]      = event_i.amo;
  assign inc[STAT_MISS_LD]  = event_i.miss_ld;
  assign inc[STAT_MISS_ST]  = event_i.miss_st;
  assign inc[STAT_MISS_CYC] = event_i.miss_cycle;
  assign inc[STAT_IDLE_CYC] = event_i.idle_cycle;
  assign inc[STAT_DMA_RD]   = event_i.dma_read;
  assign inc[STAT_DMA_WR]   = event_i.dma_write;

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N_STAT; i++) begin
      if (reset_i) begin
        ctr_r[i] <= '0;
      end else if (inc[i] & ~(&ctr_r[i])) begin
        ctr_r[i] <= ctr_r[i] + 1'b1;  // holds at max
      end
    end
  end

  always_comb begin
    stat_o = '0;
    for (int i = 0; i < N_STAT; i++) begin
      if (int'(stat_sel_i) == i) begin
        stat_o = ctr_r[i];
      end
    end
  end

endmodule

// ==== verilog/vcache_top.sv ====
// vector cache slice: decode, execute and result stages plus the profiler
// requests use valid/ready, responses and DMA packets use valid/yumi
// dma_addr_o is a word address; every DMA transfer is one word
// yumi_i and dma_yumi_i may only be raised while the matching valid is high
`timescale 1ns/1ps
`include "vcache_params.svh"

module vcache_top
  import vcache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_v_i,
  output logic                    req_ready_o,
  input  vcache_op_e              req_op_i,
  input  logic [`VC_ADDR_W-1:0]   req_addr_i,
  input  logic [`VC_DATA_W-1:0]   req_data_i,
  input  logic [`VC_DATA_W/8-1:0] req_mask_i,
  input  logic [1:0]              req_size_i,
  input  logic                    req_sigext_i,
  output logic                    v_o,
  output logic [`VC_DATA_W-1:0]   data_o,
  input  logic                    yumi_i,
  output logic                    dma_v_o,
  output logic                    dma_write_o,
  output logic [`VC_ADDR_W-3:0]   dma_addr_o,
  output logic [`VC_DATA_W-1:0]   dma_data_o,
  input  logic                    dma_yumi_i,
  input  logic                    dma_data_v_i,
  input  logic [`VC_DATA_W-1:0]   dma_data_i,
  input  vcache_stat_e            stat_sel_i,
  output logic [`VC_CTR_W-1:0]    stat_o
);

  vcache_stage_if #(.payload_t(vcache_decode_s)) dec_exe ();
  vcache_stage_if #(.payload_t(vcache_resp_s))   exe_res ();

  vcache_dma_pkt_s dma_pkt;
  vcache_event_s   exe_event;
  vcache_event_s   res_event;
  vcache_event_s   all_event;

  vcache_decode dec (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_v_i      (req_v_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .req_mask_i   (req_mask_i),
    .req_size_i   (req_size_i),
    .req_sigext_i (req_sigext_i),
    .out_o        (dec_exe)
  );

  vcache_execute exe (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_i         (dec_exe),
    .out_o        (exe_res),
    .dma_pkt_o    (dma_pkt),
    .dma_v_o      (dma_v_o),
    .dma_yumi_i   (dma_yumi_i),
    .dma_data_v_i (dma_data_v_i),
    .dma_data_i   (dma_data_i),
    .event_o      (exe_event)
  );

  vcache_result res (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in_i    (exe_res),
    .v_o     (v_o),
    .data_o  (data_o),
    .yumi_i  (yumi_i),
    .event_o (res_event)
  );

  // the two sources never drive the same field
  assign all_event = exe_event | res_event;

  vcache_profiler prof (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .event_i    (all_event),
    .stat_sel_i (stat_sel_i),
    .stat_o     (stat_o)
  );

  assign dma_write_o = dma_pkt.write_not_read;
  assign dma_addr_o  = dma_pkt.addr;
  assign dma_data_o  = dma_pkt.data;

endmodule

// ==== bench/vcache_asserts.sv ====
// handshake and reset rules on the ports of vcache_top
// attached to every vcache_top instance by the bind below
`timescale 1ns/1ps

module vcache_asserts (
  input logic        clk_i,
  input logic        reset_i,
  input logic        req_ready_o,
  input logic        v_o,
  input logic [31:0] data_o,
  input logic        yumi_i,
  input logic        dma_v_o,
  input logic        dma_write_o,
  input logic [13:0] dma_addr_o,
  input logic [31:0] dma_data_o,
  input logic        dma_yumi_i
);

  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(data_o))
    else $error("response dropped or changed before yumi");

  a_dma_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_v_o && !dma_yumi_i |=> dma_v_o && $stable({dma_write_o, dma_addr_o, dma_data_o}))
    else $error("dma packet dropped or changed before yumi");

  // first cycle out of reset is quiet
  a_reset_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(reset_i) |-> !req_ready_o && !v_o && !dma_v_o)
    else $error("outputs active in the first cycle after reset");

  // a taken read leaves the packet port idle until its data is back
  a_one_read: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_v_o && dma_yumi_i && !dma_write_o |=> !dma_v_o)
    else $error("new dma packet while a read is still outstanding");

endmodule

bind vcache_top vcache_asserts asrt (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_ready_o (req_ready_o),
  .v_o         (v_o),
  .data_o      (data_o),
  .yumi_i      (yumi_i),
  .dma_v_o     (dma_v_o),
  .dma_write_o (dma_write_o),
  .dma_addr_o  (dma_addr_o),
  .dma_data_o  (dma_data_o),
  .dma_yumi_i  (dma_yumi_i)
);

// ==== bench/vcache_checker.sv ====
// shadow cache and memory that predict every response, DMA packet and counter
// assumes 4 sets, 16-bit byte addresses, and memory filled by fill_word
// samples on the rising edge; inputs are driven on the falling edge
`timescale 1ns/1ps

module vcache_checker
  import vcache_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         req_v_i,
  input  logic         req_ready_o,
  input  vcache_op_e   req_op_i,
  input  logic [15:0]  req_addr_i,
  input  logic [31:0]  req_data_i,
  input  logic [3:0]   req_mask_i,
  input  logic [1:0]   req_size_i,
  input  logic         req_sigext_i,
  input  logic         miss_exp_i,
  input  logic         v_o,
  input  logic [31:0]  data_o,
  input  logic         yumi_i,
  input  logic         dma_v_o,
  input  logic         dma_write_o,
  input  logic [13:0]  dma_addr_o,
  input  logic [31:0]  dma_data_o,
  input  logic         dma_yumi_i,
  input  logic         stat_check_i,
  input  vcache_stat_e stat_sel_i,
  input  logic [31:0]  stat_o,
  output int           data_errs_o,
  output int           dma_errs_o,
  output int           stat_errs_o,
  output int           pending_o
);

  logic [11:0]     stag [4];
  logic [31:0]     sdata [4];
  logic [3:0]      sv;
  logic [3:0]      sd;
  logic [31:0]     smem [logic [13:0]];
  logic [31:0]     resp_q [$];
  vcache_dma_pkt_s dma_q [$];
  int              exp_cnt [9];

  function automatic logic [31:0] fill_word(input logic [13:0] a);
    return {2'b10, a, 2'b01, ~a};  // every address bit shows up
  endfunction

  function automatic logic [31:0] extend(input logic [31:0] w, input logic [1:0] off,
                                         input logic [1:0] size, input logic sign);
    logic [31:0] s;
    s = w >> (8 * off);
    case (size)
      2'b00:   return {{24{sign & s[7]}}, s[7:0]};
      2'b01:   return {{16{sign & s[15]}}, s[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic push_write(input logic [1:0] idx);
    dma_q.push_back('{1'b1, {stag[idx], idx}, sdata[idx]});
    smem[{stag[idx], idx}] = sdata[idx];
    exp_cnt[STAT_DMA_WR]++;
  endtask

  task automatic model_request();
    logic [1:0]  idx;
    logic [11:0] tag;
    logic [13:0] wa;
    logic        hit;
    logic        miss;
    logic [31:0] old;
    idx  = req_addr_i[3:2];
    tag  = req_addr_i[15:4];
    wa   = req_addr_i[15:2];
    hit  = sv[idx] && (stag[idx] == tag);
    miss = !hit && (req_op_i inside {OP_LD, OP_SM, OP_AMOSWAP, OP_AMOOR});
    if (miss !== miss_exp_i) begin
      $display("[ERROR] miss class: got %h expected %h", miss, miss_exp_i);
      data_errs_o++;
    end
    if (miss) begin
      if (sv[idx] && sd[idx]) push_write(idx);  // dirty victim first
      dma_q.push_back('{1'b0, wa, 32'h0});
      exp_cnt[STAT_DMA_RD]++;
      sdata[idx] = smem.exists(wa) ? smem[wa] : fill_word(wa);
      stag[idx]  = tag;
      sv[idx]    = 1'b1;
      sd[idx]    = 1'b0;
      if (req_op_i == OP_LD) exp_cnt[STAT_MISS_LD]++;
      if (req_op_i == OP_SM) exp_cnt[STAT_MISS_ST]++;
    end
    old = sdata[idx];
    case (req_op_i)
      OP_LD: begin
        resp_q.push_back(extend(old, req_addr_i[1:0], req_size_i, req_sigext_i));
        exp_cnt[STAT_LD]++;
      end
      OP_SM: begin
        for (int b = 0; b < 4; b++) begin
          if (req_mask_i[b]) sdata[idx][8*b +: 8] = req_data_i[8*b +: 8];
        end
        sd[idx] = 1'b1;
        resp_q.push_back(32'h0);
        exp_cnt[STAT_ST]++;
      end
      OP_AMOSWAP, OP_AMOOR: begin
        sdata[idx] = (req_op_i == OP_AMOOR) ? (old | req_data_i) : req_data_i;
        sd[idx]    = 1'b1;
        resp_q.push_back(old);  // amo always returns the full old word
        exp_cnt[STAT_AMO]++;
      end
      OP_AFL: begin
        if (hit && sd[idx]) begin
          push_write(idx);
          sd[idx] = 1'b0;
        end
        resp_q.push_back(32'h0);
      end
      default: begin
        if (hit) begin
          sv[idx] = 1'b0;  // unflushed data is gone
          sd[idx] = 1'b0;
        end
        resp_q.push_back(32'h0);
      end
    endcase
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      sv = '0;
      sd = '0;
      data_errs_o = 0;
      dma_errs_o  = 0;
      stat_errs_o = 0;
      foreach (exp_cnt[i]) exp_cnt[i] = 0;
    end else begin
      if (dma_v_o && dma_yumi_i) begin
        if (dma_q.size() == 0) begin
          $display("a dma packet was issued when none was expected");
          dma_errs_o++;
        end else begin
          if (dma_write_o !== dma_q[0].write_not_read) begin
            $display("[ERROR] dma_write_o: got %h expected %h", dma_write_o,
                     dma_q[0].write_not_read);
            dma_errs_o++;
          end
          if (dma_addr_o !== dma_q[0].addr) begin
            $display("[ERROR] dma_addr_o: got %h expected %h", dma_addr_o, dma_q[0].addr);
            dma_errs_o++;
          end
          if (dma_q[0].write_not_read && dma_data_o !== dma_q[0].data) begin
            $display("[ERROR] dma_data_o: got %h expected %h", dma_data_o, dma_q[0].data);
            dma_errs_o++;
          end
          void'(dma_q.pop_front());
        end
      end
      if (v_o && yumi_i) begin
        if (resp_q.size() == 0) begin
          $display("a response came back with no request outstanding");
          data_errs_o++;
        end else begin
          if (data_o !== resp_q[0]) begin
            $display("[ERROR] data_o: got %h expected %h", data_o, resp_q[0]);
            data_errs_o++;
          end
          void'(resp_q.pop_front());
        end
      end
      if (req_v_i && req_ready_o) model_request();
      if (stat_check_i) begin
        if (stat_sel_i inside {STAT_MISS_CYC, STAT_IDLE_CYC}) begin
          if (stat_o == 0) begin
            $display("cycle counter %0d is still zero at the end", stat_sel_i);
            stat_errs_o++;
          end
        end else if (stat_o !== exp_cnt[stat_sel_i]) begin
          $display("[ERROR] stat_o[%0d]: got %h expected %h", stat_sel_i, stat_o,
                   exp_cnt[stat_sel_i]);
          stat_errs_o++;
        end
      end
    end
    pending_o = resp_q.size() + dma_q.size();
  end

endmodule

// ==== bench/vcache_tb.sv ====
// testbench for vcache_top: table-driven requests, random back-pressure
// the DMA memory starts out with the same fill pattern as the checker
// inputs change on the falling edge, results are judged by vcache_checker
`timescale 1ns/1ps

module vcache_tb
  import vcache_pkg::*;
();

  localparam int N_TESTS = 26;
  localparam int LIMIT   = 40 * N_TESTS + 200;

  typedef struct packed {
    vcache_op_e  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [1:0]  size;  // 0 byte, 1 half, 2 word
    logic        sign;
    logic        miss;  // line has to be fetched
  } entry_t;

  logic         clk_i, reset_i;
  logic         req_v_i, req_ready_o, req_sigext_i, miss_exp;
  vcache_op_e   req_op_i;
  logic [15:0]  req_addr_i;
  logic [31:0]  req_data_i, data_o, dma_data_o, dma_data_i, stat_o;
  logic [3:0]   req_mask_i;
  logic [1:0]   req_size_i;
  logic         v_o, yumi_i, dma_v_o, dma_write_o, dma_yumi_i, dma_data_v_i;
  logic [13:0]  dma_addr_o;
  vcache_stat_e stat_sel_i;
  logic         stat_check;
  int           data_errs, dma_errs, stat_errs, pending, cycles;

  entry_t       tbl [N_TESTS];
  logic [31:0]  mem [logic [13:0]];
  logic [31:0]  rng;
  logic         pkt_taken, pkt_write, rd_pending;
  logic [13:0]  pkt_addr, rd_addr;
  logic [31:0]  pkt_data;
  logic [1:0]   gap, rd_wait;

  vcache_top uut (.*);

  vcache_checker chk (
    .miss_exp_i (miss_exp), .stat_check_i (stat_check), .data_errs_o (data_errs),
    .dma_errs_o (dma_errs), .stat_errs_o (stat_errs), .pending_o (pending), .*
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] read_mem(input logic [13:0] a);
    return mem.exists(a) ? mem[a] : {2'b10, a, 2'b01, ~a};
  endfunction

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  // DMA memory and response yumi, both with random delays
  always @(negedge clk_i) begin
    if (reset_i) begin
      yumi_i = 0;
      dma_yumi_i = 0;
      dma_data_v_i = 0;
      pkt_taken = 0;
      rd_pending = 0;
      gap = 0;
    end else begin
      rng = xorshift(rng);
      if (pkt_taken) begin  // packet left at the last rising edge
        if (pkt_write) begin
          mem[pkt_addr] = pkt_data;
        end else begin
          rd_pending = 1;
          rd_addr = pkt_addr;
          rd_wait = rng[9:8];
        end
        pkt_taken = 0;
      end
      yumi_i = v_o && (rng[1:0] != 2'b00);
      dma_yumi_i = 0;
      dma_data_v_i = 0;
      if (rd_pending) begin
        if (rd_wait == 0) begin
          dma_data_v_i = 1;
          dma_data_i = read_mem(rd_addr);
          rd_pending = 0;
        end else begin
          rd_wait--;
        end
      end else if (dma_v_o) begin
        if (gap == 0) begin
          dma_yumi_i = 1;
          pkt_taken = 1;
          pkt_write = dma_write_o;
          pkt_addr = dma_addr_o;
          pkt_data = dma_data_o;
          gap = rng[5:4];
        end else begin
          gap--;
        end
      end
    end
  end

  task automatic send_entry(input entry_t e);
    logic taken;
    req_v_i = 1;
    req_op_i = e.op;
    req_addr_i = e.addr;
    req_data_i = e.data;
    req_mask_i = e.mask;
    req_size_i = e.size;
    req_sigext_i = e.sign;
    miss_exp = e.miss;
    taken = 0;
    while (!taken) begin
      @(posedge clk_i);
      taken = req_ready_o;
      @(negedge clk_i);
    end
    req_v_i = 0;
  endtask

  initial begin
    clk_i = 0;
    reset_i = 1;
    req_v_i = 0;
    req_op_i = OP_LD;
    req_addr_i = 0;
    req_data_i = 0;
    req_mask_i = 0;
    req_size_i = 0;
    req_sigext_i = 0;
    miss_exp = 0;
    yumi_i = 0;
    dma_yumi_i = 0;
    dma_data_v_i = 0;
    dma_data_i = 0;
    stat_sel_i = STAT_LD;
    stat_check = 0;
    cycles = 0;
    rng = 32'h851a;
    tbl[0]  = '{OP_LD,      16'h0010, 32'h0,         4'h0, 2'd2, 1'b0, 1'b1};
    tbl[1]  = '{OP_SM,      16'h0010, 32'h887766f5,  4'h5, 2'd2, 1'b0, 1'b0};
    tbl[2]  = '{OP_LD,      16'h0010, 32'h0,         4'h0, 2'd0, 1'b1, 1'b0};
    tbl[3]  = '{OP_LD,      16'h0012, 32'h0,         4'h0, 2'd0, 1'b0, 1'b0};
    tbl[4]  = '{OP_LD,      16'h0012, 32'h0,         4'h0, 2'd1, 1'b1, 1'b0};
    tbl[5]  = '{OP_LD,      16'h0010, 32'h0,         4'h0, 2'd1, 1'b0, 1'b0};
    tbl[6]  = '{OP_LD,      16'h0013, 32'h0,         4'h0, 2'd0, 1'b1, 1'b0};
    tbl[7]  = '{OP_SM,      16'h0024, 32'ha1b2c3d4,  4'hc, 2'd2, 1'b0, 1'b1};
    tbl[8]  = '{OP_LD,      16'h0050, 32'h0,         4'h0, 2'd2, 1'b0, 1'b1};  // dirty victim
    tbl[9]  = '{OP_LD,      16'h0010, 32'h0,         4'h0, 2'd0, 1'b1, 1'b1};
    tbl[10] = '{OP_AMOSWAP, 16'h0014, 32'h12345678,  4'hf, 2'd2, 1'b0, 1'b1};
    tbl[11] = '{OP_LD,      16'h0014, 32'h0,         4'h0, 2'd2, 1'b0, 1'b0};
    tbl[12] = '{OP_AMOOR,   16'h0014, 32'h80000001,  4'hf, 2'd2, 1'b0, 1'b0};
    tbl[13] = '{OP_LD,      16'h0014, 32'h0,         4'h0, 2'd2, 1'b0, 1'b0};
    tbl[14] = '{OP_AFL,     16'h0014, 32'h0,         4'h0, 2'd2, 1'b0, 1'b0};
    tbl[15] = '{OP_AFL,     16'h0014, 32'h0,         4'h0, 2'd2, 1'b0, 1'b0};  // already clean
    tbl[16] = '{OP_SM,      16'h0018, 32'hdeadbeef,  4'hf, 2'd2, 1'b0, 1'b1};
    tbl[17] = '{OP_AINV,    16'h0018, 32'h0,         4'h0, 2'd2, 1'b0, 1'b0};
    tbl[18] = '{OP_LD,      16'h0018, 32'h0,         4'h0, 2'd2, 1'b0, 1'b1};  // store lost
    tbl[19] = '{OP_AFL,     16'h0030, 32'h0,         4'h0, 2'd2, 1'b0, 1'b0};
    tbl[20] = '{OP_LD,      16'h0038, 32'h0,         4'h0, 2'd1, 1'b1, 1'b1};
    tbl[21] = '{OP_SM,      16'h001c, 32'h00008001,  4'h3, 2'd2, 1'b0, 1'b1};
    tbl[22] = '{OP_LD,      16'h001c, 32'h0,         4'h0, 2'd1, 1'b1, 1'b0};
    tbl[23] = '{OP_LD,      16'h001e, 32'h0,         4'h0, 2'd1, 1'b1, 1'b0};
    tbl[24] = '{OP_AMOOR,   16'h002c, 32'h0f0f0f0f,  4'hf, 2'd2, 1'b0, 1'b1};
    tbl[25] = '{OP_LD,      16'h001d, 32'h0,         4'h0, 2'd0, 1'b0, 1'b1};
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 0;
    for (int i = 0; i < N_TESTS; i++) begin
      send_entry(tbl[i]);
    end
    while (pending != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);  // late DMA events reach the counters
    for (int s = 0; s <= int'(STAT_DMA_WR); s++) begin
      stat_sel_i = vcache_stat_e'(s);
      stat_check = 1;
      @(negedge clk_i);
    end
    stat_check = 0;
    $display("errors: data=%0d dma=%0d stat=%0d", data_errs, dma_errs, stat_errs);
    if (data_errs + dma_errs + stat_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/vcache_pkg.sv
verilog/vcache_stage_if.sv
verilog/vcache_decode.sv
verilog/vcache_execute.sv
verilog/vcache_result.sv
verilog/vcache_profiler.sv
verilog/vcache_top.sv
bench/vcache_asserts.sv
bench/vcache_checker.sv
bench/vcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vcache_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
